//--- arcade_shell.f
verilog/input_pkg.sv
verilog/av_pkg.sv
verilog/key_latch.sv
verilog/control_mapper.sv
verilog/video_gate.sv
verilog/sigma_delta_dac.sv
verilog/arcade_shell.sv
tb/arcade_shell_assertions.sv
tb/tb_arcade_shell.sv

//--- tb/arcade_shell_assertions.sv
// Concurrent checks for the arcade shell
// Pixel enable spacing, colour blanking after a blank and the
// reset value of the first game input register

`timescale 1ns/1ps

module arcade_shell_assertions (
	input logic               clk_sys,
	input logic               rst,
	input logic               pix_ce,
	input logic               game_hblank,
	input logic               game_vblank,
	input av_pkg::color_rg_t  vga_r,
	input av_pkg::color_rg_t  vga_g,
	input av_pkg::color_b_t   vga_b,
	input input_pkg::in_reg_t in0_reg
);

	int fail_count = 0;	// Read by the testbench at the end of the run

	// ========================================================================
	// Pixel enable
	// ========================================================================
	a_ce_single: assert property (@(posedge clk_sys) disable iff (rst)
		pix_ce |=> !pix_ce)
		else begin
			fail_count++;
			$error("pix_ce high in two consecutive cycles");
		end

	a_ce_period: assert property (@(posedge clk_sys) disable iff (rst)
		pix_ce |=> (!pix_ce [*(av_pkg::CE_DIV - 1)]) ##1 pix_ce)
		else begin
			fail_count++;
			$error("pix_ce pulses not CE_DIV cycles apart");
		end

	// Black one cycle after either blank
	a_blank: assert property (@(posedge clk_sys) disable iff (rst)
		(game_hblank || game_vblank) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else begin
			fail_count++;
			$error("vga colour not zero after blank");
		end

	a_rst_in0: assert property (@(posedge clk_sys) rst |=> (in0_reg == '1))
		else begin
			fail_count++;
			$error("in0_reg not all ones in reset");
		end

endmodule

bind arcade_shell arcade_shell_assertions u_arcade_shell_assertions (
	.clk_sys     (clk_sys),
	.rst         (rst),
	.pix_ce      (pix_ce),
	.game_hblank (game_hblank),
	.game_vblank (game_vblank),
	.vga_r       (vga_r),
	.vga_g       (vga_g),
	.vga_b       (vga_b),
	.in0_reg     (in0_reg)
);

//--- tb/tb_arcade_shell.sv
// Testbench for the arcade shell
// LFSR stimulus on the falling edge, a cycle model of the input,
// video and reset paths, and 256-cycle density windows on the DAC

`timescale 1ns/1ps

module tb_arcade_shell;

	logic clk_sys, rst;
	logic key_strobe, key_pressed;
	logic [7:0] key_code;
	input_pkg::joy_t joy_0, joy_1;
	logic rotate, status_reset, reset_button;
	input_pkg::in_reg_t in0_reg, in1_reg;
	logic game_reset;
	av_pkg::color_rg_t game_r, game_g, vga_r, vga_g;
	av_pkg::color_b_t game_b, vga_b;
	logic game_hs, game_vs, game_hblank, game_vblank;
	logic pix_ce, vga_hs, vga_vs;
	av_pkg::sample_t sample;
	logic audio_bit;

	// Model state
	logic [31:0] lfsr;
	int cyc;	// Rising edges since reset release
	input_pkg::btn_vec_t btns_m;
	logic [7:0] sc_table [10];
	input_pkg::in_reg_t exp_in0, exp_in1;
	av_pkg::color_rg_t exp_r, exp_g;
	av_pkg::color_b_t exp_b;
	logic exp_greset, exp_hs, exp_vs;

	arcade_shell u_arcade_shell (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// One step of the x^32+x^22+x^2+x+1 register per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run stopped");
	endtask

	// ========================================================================
	// Compare tasks
	// ========================================================================
	task automatic check_in_reg(input string name, input input_pkg::in_reg_t e,
		input input_pkg::in_reg_t a);
		if (a !== e)
			stop_on_error($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, e, a));
	endtask

	task automatic check_color_rg(input string name, input av_pkg::color_rg_t e,
		input av_pkg::color_rg_t a);
		if (a !== e)
			stop_on_error($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, e, a));
	endtask

	task automatic check_color_b(input string name, input av_pkg::color_b_t e,
		input av_pkg::color_b_t a);
		if (a !== e)
			stop_on_error($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, e, a));
	endtask

	task automatic check_bit(input string name, input logic e, input logic a);
		if (a !== e)
			stop_on_error($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, e, a));
	endtask

	task automatic check_density(input string name, input av_pkg::sample_t e,
		input av_pkg::sample_t a);
		if (a !== e)
			stop_on_error($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, e, a));
	endtask

	// Expected outputs after the next rising edge, then the key event
	task automatic predict();
		logic up_s, dn_s, lf_s, rt_s, up, dn, lf, rt;
		input_pkg::in_reg_t w0, w1;
		up_s = btns_m[input_pkg::BTN_UP] | joy_0[input_pkg::JOY_UP] | joy_1[input_pkg::JOY_UP];
		dn_s = btns_m[input_pkg::BTN_DOWN] | joy_0[input_pkg::JOY_DOWN]
			| joy_1[input_pkg::JOY_DOWN];
		lf_s = btns_m[input_pkg::BTN_LEFT] | joy_0[input_pkg::JOY_LEFT]
			| joy_1[input_pkg::JOY_LEFT];
		rt_s = btns_m[input_pkg::BTN_RIGHT] | joy_0[input_pkg::JOY_RIGHT]
			| joy_1[input_pkg::JOY_RIGHT];
		up = rotate ? lf_s : up_s;
		dn = rotate ? rt_s : dn_s;
		lf = rotate ? dn_s : lf_s;
		rt = rotate ? up_s : rt_s;
		w0 = '0;
		w0[input_pkg::IN0_UP] = up;
		w0[input_pkg::IN0_LEFT] = lf;
		w0[input_pkg::IN0_RIGHT] = rt;
		w0[input_pkg::IN0_DOWN] = dn;
		w0[input_pkg::IN0_COIN] = btns_m[input_pkg::BTN_COIN];
		w1 = '0;
		w1[input_pkg::IN1_UP] = up;
		w1[input_pkg::IN1_FIRE] = btns_m[input_pkg::BTN_FIRE1]
			| joy_0[input_pkg::JOY_FIRE1] | joy_1[input_pkg::JOY_FIRE1];
		w1[input_pkg::IN1_START1] = btns_m[input_pkg::BTN_START1];
		w1[input_pkg::IN1_START2] = btns_m[input_pkg::BTN_START2];
		exp_in0 = ~w0;
		exp_in1 = ~w1;
		exp_greset = status_reset | reset_button;
		exp_r = (game_hblank | game_vblank) ? '0 : game_r;
		exp_g = (game_hblank | game_vblank) ? '0 : game_g;
		exp_b = (game_hblank | game_vblank) ? '0 : game_b;
		exp_hs = ~game_hs;
		exp_vs = ~game_vs;
		if (key_strobe) begin
			for (int i = 0; i < 10; i++) begin
				if (key_code == sc_table[i]) btns_m[i] = key_pressed;
			end
		end
	endtask

	task automatic next_cycle();
		@(negedge clk_sys);
		cyc++;
		check_in_reg("in0_reg", exp_in0, in0_reg);
		check_in_reg("in1_reg", exp_in1, in1_reg);
		check_bit("game_reset", exp_greset, game_reset);
		check_color_rg("vga_r", exp_r, vga_r);
		check_color_rg("vga_g", exp_g, vga_g);
		check_color_b("vga_b", exp_b, vga_b);
		check_bit("vga_hs", exp_hs, vga_hs);
		check_bit("vga_vs", exp_vs, vga_vs);
		check_bit("pix_ce", (cyc % av_pkg::CE_DIV) == 0, pix_ce);
	endtask

	task automatic drive_random(input logic keys_only);
		logic [3:0] sel;
		logic [7:0] status_word;
		key_strobe = 1'(rand_bits(1));
		key_pressed = 1'(rand_bits(1));
		sel = 4'(rand_bits(4));
		key_code = (sel < 10) ? sc_table[sel] : 8'(rand_bits(8));	// Unlisted codes too
		joy_0 = keys_only ? '0 : 8'(rand_bits(8) & rand_bits(8));	// Sparse sticks
		joy_1 = keys_only ? '0 : 8'(rand_bits(8) & rand_bits(8));
		rotate = keys_only ? 1'b0 : 1'(rand_bits(1));
		status_word = 8'(rand_bits(8));	// Menu status, only the reset bit is wired
		status_reset = status_word[input_pkg::STATUS_RESET_BIT];
		reset_button = 1'(rand_bits(1));
		{game_r, game_g, game_b} = 8'(rand_bits(8));
		{game_hs, game_vs} = 2'(rand_bits(2));
		game_hblank = (rand_bits(2) == 2'b00);
		game_vblank = (rand_bits(3) == 3'b000);
		predict();
	endtask

	initial begin
		int waited;
		int ones;
		lfsr = 32'hd200_2189;
		sc_table = '{input_pkg::SC_UP, input_pkg::SC_DOWN, input_pkg::SC_LEFT,
			input_pkg::SC_RIGHT, input_pkg::SC_COIN, input_pkg::SC_START1,
			input_pkg::SC_START2, input_pkg::SC_FIRE1, input_pkg::SC_FIRE2,
			input_pkg::SC_FIRE3};
		rst = 1'b1;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joy_0 = '0;
		joy_1 = '0;
		{rotate, status_reset, reset_button} = 3'b000;
		{game_r, game_g, game_b} = '0;
		{game_hs, game_vs, game_hblank, game_vblank} = 4'b0000;
		sample = '0;
		btns_m = '0;
		cyc = 0;
		repeat (4) @(negedge clk_sys);

		// ====================================================================
		// Reset state and first pixel enable
		// ====================================================================
		check_in_reg("in0_reg", 8'hff, in0_reg);
		check_in_reg("in1_reg", 8'hff, in1_reg);
		check_bit("game_reset", 1'b0, game_reset);
		check_bit("pix_ce", 1'b0, pix_ce);
		check_bit("audio_bit", 1'b0, audio_bit);
		check_color_rg("vga_r", '0, vga_r);
		check_color_rg("vga_g", '0, vga_g);
		check_color_b("vga_b", '0, vga_b);
		check_bit("vga_hs", 1'b1, vga_hs);
		check_bit("vga_vs", 1'b1, vga_vs);
		rst = 1'b0;
		predict();
		waited = 0;
		while (pix_ce !== 1'b1) begin
			if (waited == 16) stop_on_error("pix_ce never pulsed after reset");
			next_cycle();
			waited++;
		end
		if (cyc != 4) stop_on_error($sformatf("first pix_ce came %0d cycles after reset", cyc));

		repeat (300) begin
			drive_random(1'b1);
			next_cycle();
		end
		repeat (500) begin
			drive_random(1'b0);
			next_cycle();
		end

		// Audio density over full accumulator periods
		key_strobe = 1'b0;
		repeat (6) begin
			sample = av_pkg::sample_t'(rand_bits(8));
			ones = 0;
			repeat (256) begin
				predict();
				next_cycle();
				ones += audio_bit;
			end
			check_density("audio_bit ones", sample, av_pkg::sample_t'(ones));
		end

		next_cycle();
		if (u_arcade_shell.u_arcade_shell_assertions.fail_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			stop_on_error("bound assertions reported failures");
		end
	end

endmodule

//--- verilog/arcade_shell.sv
// Arcade board shell
// Sits between the board and the game machine. Keyboard events and
// joysticks become the game's active-low input words, menu reset and
// reset button form the game reset, the pixel enable and gated video
// go toward the scaler, and the game's audio sample drives a one-bit
// sigma-delta output.

`timescale 1ns/1ps

module arcade_shell (
	input  logic               clk_sys,
	input  logic               rst,

	// Keyboard and joysticks
	input  logic               key_strobe,
	input  logic               key_pressed,
	input  logic [7:0]         key_code,
	input  input_pkg::joy_t    joy_0,
	input  input_pkg::joy_t    joy_1,
	input  logic               rotate,
	input  logic               status_reset,
	input  logic               reset_button,

	// Toward the game machine
	output input_pkg::in_reg_t in0_reg,
	output input_pkg::in_reg_t in1_reg,
	output logic               game_reset,

	// Game video in, scaler video out
	input  av_pkg::color_rg_t  game_r,
	input  av_pkg::color_rg_t  game_g,
	input  av_pkg::color_b_t   game_b,
	input  logic               game_hs,
	input  logic               game_vs,
	input  logic               game_hblank,
	input  logic               game_vblank,
	output logic               pix_ce,
	output av_pkg::color_rg_t  vga_r,
	output av_pkg::color_rg_t  vga_g,
	output av_pkg::color_b_t   vga_b,
	output logic               vga_hs,
	output logic               vga_vs,

	// Audio
	input  av_pkg::sample_t    sample,
	output logic               audio_bit
);

	input_pkg::btn_vec_t btns;	// Held keyboard buttons

	// ========================================================================
	// Input side
	// ========================================================================
	key_latch u_key_latch (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.btns        (btns)
	);

	control_mapper u_control_mapper (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.btns         (btns),
		.joy_0        (joy_0),
		.joy_1        (joy_1),
		.rotate       (rotate),
		.status_reset (status_reset),
		.reset_button (reset_button),
		.in0_reg      (in0_reg),
		.in1_reg      (in1_reg),
		.game_reset   (game_reset)
	);

	// ========================================================================
	// Video and audio
	// ========================================================================
	video_gate u_video_gate (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.game_r      (game_r),
		.game_g      (game_g),
		.game_b      (game_b),
		.game_hs     (game_hs),
		.game_vs     (game_vs),
		.game_hblank (game_hblank),
		.game_vblank (game_vblank),
		.pix_ce      (pix_ce),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs)
	);

	sigma_delta_dac u_sigma_delta_dac (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.sample    (sample),
		.audio_bit (audio_bit)
	);

endmodule

//--- verilog/av_pkg.sv
// Audio and video definitions for the arcade shell
// Colour channel widths, audio sample width and the pixel enable ratio

package av_pkg;

	// ========================================================================
	// Video
	// ========================================================================
	localparam int COLOR_RG_W = 3;	// Red and green
	localparam int COLOR_B_W  = 2;	// Blue has one bit less

	typedef logic [COLOR_RG_W-1:0] color_rg_t;
	typedef logic [COLOR_B_W-1:0]  color_b_t;

	// clk_sys cycles per pixel enable
	localparam int CE_DIV   = 4;
	localparam int CE_CNT_W = $clog2(CE_DIV);

	// ========================================================================
	// Audio
	// ========================================================================
	localparam int SAMPLE_W = 8;

	typedef logic [SAMPLE_W-1:0] sample_t;

endpackage

//--- verilog/control_mapper.sv
// Control mapper
// Merges keyboard buttons with both joysticks per direction, applies
// the optional 90 degree control rotation and registers the two
// active-low game input words. Also combines the menu reset and the
// reset button into the game reset.

`timescale 1ns/1ps

module control_mapper (
	input  logic                clk_sys,
	input  logic                rst,
	input  input_pkg::btn_vec_t btns,
	input  input_pkg::joy_t     joy_0,
	input  input_pkg::joy_t     joy_1,
	input  logic                rotate,
	input  logic                status_reset,
	input  logic                reset_button,
	output input_pkg::in_reg_t  in0_reg,
	output input_pkg::in_reg_t  in1_reg,
	output logic                game_reset
);

	// Merged sources, before rotation
	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;
	input_pkg::in_reg_t in0_hi;	// Active-high form of in0_reg
	input_pkg::in_reg_t in1_hi;

	assign src_up    = btns[input_pkg::BTN_UP] | joy_0[input_pkg::JOY_UP]
		| joy_1[input_pkg::JOY_UP];
	assign src_down  = btns[input_pkg::BTN_DOWN] | joy_0[input_pkg::JOY_DOWN]
		| joy_1[input_pkg::JOY_DOWN];
	assign src_left  = btns[input_pkg::BTN_LEFT] | joy_0[input_pkg::JOY_LEFT]
		| joy_1[input_pkg::JOY_LEFT];
	assign src_right = btns[input_pkg::BTN_RIGHT] | joy_0[input_pkg::JOY_RIGHT]
		| joy_1[input_pkg::JOY_RIGHT];

	// Rotated cabinet turns the stick a quarter turn
	assign m_up    = rotate ? src_left  : src_up;
	assign m_down  = rotate ? src_right : src_down;
	assign m_left  = rotate ? src_down  : src_left;
	assign m_right = rotate ? src_up    : src_right;

	assign m_fire = btns[input_pkg::BTN_FIRE1] | joy_0[input_pkg::JOY_FIRE1]
		| joy_1[input_pkg::JOY_FIRE1];

	// ========================================================================
	// Register layout, unused bits stay 0 here and read 1 after inversion
	// ========================================================================
	always_comb begin
		in0_hi = '0;
		in0_hi[input_pkg::IN0_UP]    = m_up;
		in0_hi[input_pkg::IN0_LEFT]  = m_left;
		in0_hi[input_pkg::IN0_RIGHT] = m_right;
		in0_hi[input_pkg::IN0_DOWN]  = m_down;
		in0_hi[input_pkg::IN0_COIN]  = btns[input_pkg::BTN_COIN];

		in1_hi = '0;
		in1_hi[input_pkg::IN1_UP]     = m_up;
		in1_hi[input_pkg::IN1_FIRE]   = m_fire;
		in1_hi[input_pkg::IN1_START1] = btns[input_pkg::BTN_START1];
		in1_hi[input_pkg::IN1_START2] = btns[input_pkg::BTN_START2];
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			in0_reg    <= '1;	// Nothing pressed
			in1_reg    <= '1;
			game_reset <= 1'b0;
		end else begin
			in0_reg    <= ~in0_hi;
			in1_reg    <= ~in1_hi;
			game_reset <= status_reset | reset_button;
		end
	end

endmodule

//--- verilog/input_pkg.sv
// Input definitions for the arcade shell
// Keyboard scan codes, held-button indices, joystick bit positions
// and the bit layout of the two active-low game input registers

package input_pkg;

	// ========================================================================
	// Keyboard scan codes (set 2 make codes)
	// ========================================================================
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_COIN   = 8'h76;	// ESC
	localparam logic [7:0] SC_START1 = 8'h05;	// F1
	localparam logic [7:0] SC_START2 = 8'h06;	// F2
	localparam logic [7:0] SC_FIRE1  = 8'h29;	// Space
	localparam logic [7:0] SC_FIRE2  = 8'h11;	// Alt
	localparam logic [7:0] SC_FIRE3  = 8'h14;	// Ctrl

	// Held-button vector and its bit indices
	typedef logic [9:0] btn_vec_t;

	localparam int BTN_UP     = 0;
	localparam int BTN_DOWN   = 1;
	localparam int BTN_LEFT   = 2;
	localparam int BTN_RIGHT  = 3;
	localparam int BTN_COIN   = 4;
	localparam int BTN_START1 = 5;
	localparam int BTN_START2 = 6;
	localparam int BTN_FIRE1  = 7;
	localparam int BTN_FIRE2  = 8;
	localparam int BTN_FIRE3  = 9;

	// ========================================================================
	// Joystick word, active high
	// ========================================================================
	typedef logic [7:0] joy_t;

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	// Game input registers, active low on the register itself
	typedef logic [7:0] in_reg_t;

	localparam int IN0_UP     = 0;
	localparam int IN0_LEFT   = 1;
	localparam int IN0_RIGHT  = 2;
	localparam int IN0_DOWN   = 3;
	localparam int IN0_COIN   = 5;

	localparam int IN1_UP     = 2;
	localparam int IN1_FIRE   = 4;
	localparam int IN1_START1 = 5;
	localparam int IN1_START2 = 6;

	localparam int STATUS_RESET_BIT = 0;	// Menu reset bit in the status word

endpackage

//--- verilog/key_latch.sv
// Keyboard button latch
// Each scan-code event writes the press state into the matching
// button bit, so btns holds the current up/down level of every key.
// Codes that are not in the list leave all bits alone.

`timescale 1ns/1ps

module key_latch (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                key_strobe,	// One-cycle event pulse
	input  logic                key_pressed,	// 1 make, 0 break
	input  logic [7:0]          key_code,
	output input_pkg::btn_vec_t btns
);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			btns <= '0;
		end else if (key_strobe) begin
			case (key_code)
				input_pkg::SC_UP: begin
					btns[input_pkg::BTN_UP] <= key_pressed;
				end
				input_pkg::SC_DOWN: begin
					btns[input_pkg::BTN_DOWN] <= key_pressed;
				end
				input_pkg::SC_LEFT: begin
					btns[input_pkg::BTN_LEFT] <= key_pressed;
				end
				input_pkg::SC_RIGHT: begin
					btns[input_pkg::BTN_RIGHT] <= key_pressed;
				end
				input_pkg::SC_COIN: begin
					btns[input_pkg::BTN_COIN] <= key_pressed;
				end
				input_pkg::SC_START1: begin
					btns[input_pkg::BTN_START1] <= key_pressed;
				end
				input_pkg::SC_START2: begin
					btns[input_pkg::BTN_START2] <= key_pressed;
				end
				input_pkg::SC_FIRE1: begin
					btns[input_pkg::BTN_FIRE1] <= key_pressed;
				end
				input_pkg::SC_FIRE2: begin
					btns[input_pkg::BTN_FIRE2] <= key_pressed;
				end
				input_pkg::SC_FIRE3: begin
					btns[input_pkg::BTN_FIRE3] <= key_pressed;
				end
				default: begin
					// Unlisted code, nothing held changes
				end
			endcase
		end
	end

endmodule

//--- verilog/sigma_delta_dac.sv
// First-order sigma-delta audio DAC
// Accumulates the unsigned sample modulo 2^SAMPLE_W every cycle and
// sends out the carry, so the density of ones follows the sample.
// With a constant sample s, any 256-cycle window holds exactly s ones.

`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic            clk_sys,
	input  logic            rst,
	input  av_pkg::sample_t sample,
	output logic            audio_bit
);

	av_pkg::sample_t           acc;
	logic [av_pkg::SAMPLE_W:0] sum;	// One extra bit for the carry

	assign sum = {1'b0, acc} + {1'b0, sample};

	// ========================================================================
	// Accumulator and output bit
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= sum[av_pkg::SAMPLE_W-1:0];	// Wraps modulo 256
			audio_bit <= sum[av_pkg::SAMPLE_W];
		end
	end

endmodule

//--- verilog/video_gate.sv
// Video output gate
// Divides clk_sys down to the pixel clock enable and prepares the
// game's pixels for the scaler: colour forced to black during either
// blank, syncs inverted to the scaler's polarity. One register stage.

`timescale 1ns/1ps

module video_gate (
	input  logic              clk_sys,
	input  logic              rst,
	input  av_pkg::color_rg_t game_r,
	input  av_pkg::color_rg_t game_g,
	input  av_pkg::color_b_t  game_b,
	input  logic              game_hs,
	input  logic              game_vs,
	input  logic              game_hblank,
	input  logic              game_vblank,
	output logic              pix_ce,
	output av_pkg::color_rg_t vga_r,
	output av_pkg::color_rg_t vga_g,
	output av_pkg::color_b_t  vga_b,
	output logic              vga_hs,
	output logic              vga_vs
);

	logic [av_pkg::CE_CNT_W-1:0] ce_cnt;
	logic                        blank;

	// ========================================================================
	// Pixel enable, one pulse every CE_DIV cycles
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ce_cnt <= '0;
			pix_ce <= 1'b0;
		end else begin
			if (ce_cnt == av_pkg::CE_CNT_W'(av_pkg::CE_DIV - 1)) begin
				ce_cnt <= '0;
			end else begin
				ce_cnt <= ce_cnt + 1'b1;
			end
			// First pulse lands on the fourth edge after reset
			pix_ce <= (ce_cnt == av_pkg::CE_CNT_W'(av_pkg::CE_DIV - 1));
		end
	end

	assign blank = game_hblank | game_vblank;

	// Colour and sync toward the scaler
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b1;	// Inverted idle sync
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= blank ? '0 : game_r;
			vga_g  <= blank ? '0 : game_g;
			vga_b  <= blank ? '0 : game_b;
			vga_hs <= ~game_hs;
			vga_vs <= ~game_vs;
		end
	end

endmodule
